// File: audio_frame_top.f
source/audio_frame_pkg.sv
source/sample_tick.sv
source/card_block_reader.sv
source/sample_fifo.sv
source/window_ring_buffer.sv
source/frame_streamer.sv
source/audio_frame_top.sv
tb/tb_clock.sv
tb/audio_frame_sva.sv
tb/audio_frame_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the audio frame testbench with Verilator and run it.
# The exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_audio_frame
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module audio_frame_tb \
    -f audio_frame_top.f \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG_FILE"; then
    exit 0
fi
echo "pass line not found in $LOG_FILE"
exit 1

// File: source/audio_frame_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// shared types and constants of the audio frame front end
//////////////////////////////////////////////////////////////////////

package audio_frame_pkg;

    // raw audio byte as stored on the card, offset binary
    typedef logic [7:0] sample_byte_t;

    // sample handed to the spectrum engine, two's complement
    typedef logic signed [15:0] frame_sample_t;

    // byte address on the storage card
    typedef logic [31:0] card_address_t;

    // bytes per card block, also the address step between blocks
    localparam int CARD_BLOCK_BYTES = 512;

    // midpoint of the offset-binary byte, maps to zero after conversion
    localparam int SAMPLE_OFFSET = 128;

endpackage

`default_nettype wire

// File: source/audio_frame_top.sv
`timescale 1ns/1ps
`default_nettype none

// card -> FIFO -> ring -> framed stream to the spectrum engine
module audio_frame_top #(
    parameter int TICK_DIVIDER = 3125,
    parameter int FRAME_LOG2   = 10,
    parameter int FIFO_LOG2    = 9
) (
    input  logic                           clock,
    input  logic                           reset,
    input  audio_frame_pkg::sample_byte_t  card_data,
    input  logic                           card_byte_strobe,
    input  logic                           frame_ready,
    output logic                           card_read,
    output audio_frame_pkg::card_address_t card_address,
    output audio_frame_pkg::frame_sample_t frame_sample,
    output logic                           frame_valid,
    output logic                           frame_last,
    output logic                           frame_done,
    output logic                           frame_overrun
);

    logic                          tick;
    logic                          fifo_write;
    audio_frame_pkg::sample_byte_t fifo_write_data;
    logic                          fifo_read;
    audio_frame_pkg::sample_byte_t fifo_read_data;
    logic                          fifo_empty;
    audio_frame_pkg::sample_byte_t ring_read_data;
    logic [FRAME_LOG2:0]           ring_read_address;
    logic                          window_start;
    logic [FRAME_LOG2:0]           window_base;
    logic                          streamer_busy;

    sample_tick #(
        .TICK_DIVIDER(TICK_DIVIDER)
    ) u_sample_tick (
        .clock(clock),
        .reset(reset),
        .tick(tick)
    );

    card_block_reader u_card_block_reader (
        .clock(clock),
        .reset(reset),
        .fifo_empty(fifo_empty),
        .card_data(card_data),
        .card_byte_strobe(card_byte_strobe),
        .card_read(card_read),
        .card_address(card_address),
        .fifo_write(fifo_write),
        .fifo_data(fifo_write_data)
    );

    // full and overflow stay internal, the reader refills only when empty
    sample_fifo #(
        .FIFO_LOG2(FIFO_LOG2)
    ) u_sample_fifo (
        .clock(clock),
        .reset(reset),
        .write(fifo_write),
        .write_data(fifo_write_data),
        .read(fifo_read),
        .read_data(fifo_read_data),
        .empty(fifo_empty),
        .full(),
        .overflow()
    );

    window_ring_buffer #(
        .FRAME_LOG2(FRAME_LOG2)
    ) u_window_ring_buffer (
        .clock(clock),
        .reset(reset),
        .tick(tick),
        .fifo_empty(fifo_empty),
        .fifo_data(fifo_read_data),
        .read_address(ring_read_address),
        .busy(streamer_busy),
        .fifo_read(fifo_read),
        .read_data(ring_read_data),
        .window_start(window_start),
        .window_base(window_base),
        .frame_overrun(frame_overrun)
    );

    frame_streamer #(
        .FRAME_LOG2(FRAME_LOG2)
    ) u_frame_streamer (
        .clock(clock),
        .reset(reset),
        .window_start(window_start),
        .window_base(window_base),
        .read_data(ring_read_data),
        .frame_ready(frame_ready),
        .busy(streamer_busy),
        .read_address(ring_read_address),
        .frame_sample(frame_sample),
        .frame_valid(frame_valid),
        .frame_last(frame_last),
        .frame_done(frame_done)
    );

endmodule

`default_nettype wire

// File: source/card_block_reader.sv
`timescale 1ns/1ps
`default_nettype none

// pulls card blocks into the sample FIFO
module card_block_reader (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          fifo_empty,
    input  audio_frame_pkg::sample_byte_t card_data,
    input  logic                          card_byte_strobe,
    output logic                          card_read,
    output audio_frame_pkg::card_address_t card_address,
    output logic                          fifo_write,
    output audio_frame_pkg::sample_byte_t fifo_data
);

    localparam int COUNT_W = $clog2(audio_frame_pkg::CARD_BLOCK_BYTES);

    logic               strobe_last;
    logic               byte_edge;
    logic [COUNT_W-1:0] byte_count;

    // a new byte is offered on each rising edge of the strobe
    assign byte_edge = card_byte_strobe && !strobe_last;

    // byte register feeding the FIFO write port
    always_ff @(posedge clock)
    begin
        if (byte_edge)
        begin
            fifo_data <= card_data;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            strobe_last  <= 1'b0;
            fifo_write   <= 1'b0;
            card_read    <= 1'b0;
            byte_count   <= '0;
            card_address <= '0;
        end
        else
        begin
            strobe_last <= card_byte_strobe;
            fifo_write  <= byte_edge;
            if (byte_edge)
            begin
                // request is acknowledged by the first byte
                card_read <= 1'b0;
                if (byte_count == COUNT_W'(audio_frame_pkg::CARD_BLOCK_BYTES - 1))
                begin
                    // block complete, next request reads the following block
                    byte_count   <= '0;
                    card_address <= card_address +
                        audio_frame_pkg::card_address_t'(audio_frame_pkg::CARD_BLOCK_BYTES);
                end
                else
                begin
                    byte_count <= byte_count + 1'b1;
                end
            end
            // ask again only between blocks and once the last byte has landed
            else if (fifo_empty && !fifo_write && byte_count == '0)
            begin
                card_read <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/frame_streamer.sv
`timescale 1ns/1ps
`default_nettype none

// streams one window from the ring as signed samples
module frame_streamer #(
    parameter int FRAME_LOG2 = 10
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           window_start,
    input  logic [FRAME_LOG2:0]            window_base,
    input  audio_frame_pkg::sample_byte_t  read_data,
    input  logic                           frame_ready,
    output logic                           busy,
    output logic [FRAME_LOG2:0]            read_address,
    output audio_frame_pkg::frame_sample_t frame_sample,
    output logic                           frame_valid,
    output logic                           frame_last,
    output logic                           frame_done
);

    logic [FRAME_LOG2:0]           sample_ptr;
    logic [FRAME_LOG2-1:0]         transfer_count;
    logic                          transfer;
    audio_frame_pkg::sample_byte_t centered;

    assign transfer = frame_valid && frame_ready;

    // read one ahead, so read_data always holds the sample at sample_ptr
    // and stays put while the engine stalls
    assign read_address = transfer ? sample_ptr + 1'b1 : sample_ptr;

    // (byte - 128) * 256, the 8-bit wrap gives the sign directly
    assign centered     = read_data -
        audio_frame_pkg::sample_byte_t'(audio_frame_pkg::SAMPLE_OFFSET);
    assign frame_sample = {centered, 8'h00};

    // last transfer of the frame
    assign frame_last = frame_valid && (&transfer_count);

    ////////////////////////////////////////////////////////////////////
    // idle -> load -> stream, busy covers load and stream
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            busy           <= 1'b0;
            frame_valid    <= 1'b0;
            frame_done     <= 1'b0;
            sample_ptr     <= '0;
            transfer_count <= '0;
        end
        else
        begin
            frame_done <= transfer && frame_last;
            if (window_start && !busy)
            begin
                busy           <= 1'b1;
                sample_ptr     <= window_base;
                transfer_count <= '0;
            end
            // load cycle, first read is in flight
            else if (busy && !frame_valid)
            begin
                frame_valid <= 1'b1;
            end
            else if (transfer)
            begin
                sample_ptr     <= sample_ptr + 1'b1;
                transfer_count <= transfer_count + 1'b1;
                if (frame_last)
                begin
                    frame_valid <= 1'b0;
                    busy        <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// byte FIFO between the card reader and the sample-rate capture
module sample_fifo #(
    parameter int FIFO_LOG2 = 9
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          write,
    input  audio_frame_pkg::sample_byte_t write_data,
    input  logic                          read,
    output audio_frame_pkg::sample_byte_t read_data,
    output logic                          empty,
    output logic                          full,
    output logic                          overflow
);

    localparam int DEPTH = 2 ** FIFO_LOG2;

    audio_frame_pkg::sample_byte_t memory [DEPTH];

    logic [FIFO_LOG2-1:0] write_ptr;
    logic [FIFO_LOG2-1:0] read_ptr;
    logic [FIFO_LOG2:0]   level;
    logic [FIFO_LOG2:0]   level_next;
    logic                 do_write;
    logic                 do_read;

    // writes into a full FIFO and reads from an empty one are ignored
    assign do_write = write && !full;
    assign do_read  = read && !empty;

    always_comb
    begin
        case ({do_write, do_read})
            2'b10:   level_next = level + 1'b1;
            2'b01:   level_next = level - 1'b1;
            default: level_next = level;
        endcase
    end

    // storage and registered read port
    always_ff @(posedge clock)
    begin
        if (do_write)
        begin
            memory[write_ptr] <= write_data;
        end
        if (do_read)
        begin
            read_data <= memory[read_ptr];
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            write_ptr <= '0;
            read_ptr  <= '0;
            level     <= '0;
            empty     <= 1'b1;
            full      <= 1'b0;
            overflow  <= 1'b0;
        end
        else
        begin
            write_ptr <= write_ptr + FIFO_LOG2'(do_write);
            read_ptr  <= read_ptr + FIFO_LOG2'(do_read);
            level     <= level_next;
            empty     <= (level_next == '0);
            full      <= (level_next == (FIFO_LOG2 + 1)'(DEPTH));
            // sticky, a lost byte corrupts every later frame
            overflow  <= overflow || (write && full);
        end
    end

endmodule

`default_nettype wire

// File: source/sample_tick.sv
`timescale 1ns/1ps
`default_nettype none

// one-cycle enable at the audio sample rate
module sample_tick #(
    parameter int TICK_DIVIDER = 3125
) (
    input  logic clock,
    input  logic reset,
    output logic tick
);

    localparam int COUNT_W = (TICK_DIVIDER > 1) ? $clog2(TICK_DIVIDER) : 1;

    logic [COUNT_W-1:0] count;

    // count wraps at TICK_DIVIDER, tick is registered on the wrap
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count == COUNT_W'(TICK_DIVIDER - 1))
        begin
            count <= '0;
            tick  <= 1'b1;
        end
        else
        begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/window_ring_buffer.sv
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// paced capture into a ring of two frames, with window triggering
//////////////////////////////////////////////////////////////////////

module window_ring_buffer #(
    parameter int FRAME_LOG2 = 10
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          tick,
    input  logic                          fifo_empty,
    input  audio_frame_pkg::sample_byte_t fifo_data,
    input  logic [FRAME_LOG2:0]           read_address,
    input  logic                          busy,
    output logic                          fifo_read,
    output audio_frame_pkg::sample_byte_t read_data,
    output logic                          window_start,
    output logic [FRAME_LOG2:0]           window_base,
    output logic                          frame_overrun
);

    localparam int RING_DEPTH = 2 ** (FRAME_LOG2 + 1);
    localparam int HOP_W      = FRAME_LOG2 - 1;

    audio_frame_pkg::sample_byte_t ring [RING_DEPTH];

    logic                write_pending;
    logic [FRAME_LOG2:0] write_ptr;
    logic [FRAME_LOG2:0] write_ptr_next;
    logic                first_hop_seen;
    logic                hop_end;
    logic                window_due;

    // pop on a tick, the byte shows on fifo_data one cycle later
    assign fifo_read      = tick && !fifo_empty;
    assign write_ptr_next = write_ptr + 1'b1;

    // low bits of the write pointer act as the hop counter
    assign hop_end    = write_pending && (&write_ptr[HOP_W-1:0]);
    // first hop only half fills the window
    assign window_due = hop_end && first_hop_seen;

    ////////////////////////////////////////////////////////////////////
    // ring memory, one write port and one read port
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (write_pending)
        begin
            ring[write_ptr] <= fifo_data;
        end
        read_data <= ring[read_address];
        // window = latest frame, starts one frame behind the next write
        if (window_due)
        begin
            window_base <= {~write_ptr_next[FRAME_LOG2], write_ptr_next[FRAME_LOG2-1:0]};
        end
    end

    ////////////////////////////////////////////////////////////////////
    // capture control
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            write_pending  <= 1'b0;
            write_ptr      <= '0;
            first_hop_seen <= 1'b0;
            window_start   <= 1'b0;
            frame_overrun  <= 1'b0;
        end
        else
        begin
            write_pending <= fifo_read;
            // a window arriving mid-stream is dropped
            window_start  <= window_due && !busy;
            if (write_pending)
            begin
                write_ptr <= write_ptr_next;
            end
            if (hop_end)
            begin
                first_hop_seen <= 1'b1;
            end
            if (window_due && busy)
            begin
                frame_overrun <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/audio_frame_sva.sv
`timescale 1ns/1ps
`default_nettype none

// stream and card address properties, bound into the DUT top level
module audio_frame_sva (
    input logic                           clock,
    input logic                           reset,
    input logic                           frame_ready,
    input logic                           frame_valid,
    input audio_frame_pkg::frame_sample_t frame_sample,
    input audio_frame_pkg::card_address_t card_address
);

    // a stalled sample stays on the bus until the engine takes it
    stall_hold : assert property (@(posedge clock) disable iff (reset)
        frame_valid && !frame_ready |=> frame_valid && $stable(frame_sample))
        else $error("frame_valid or frame_sample changed while frame_ready was low");

    // the card is only ever addressed on block boundaries
    block_aligned : assert property (@(posedge clock) disable iff (reset)
        (card_address % audio_frame_pkg::CARD_BLOCK_BYTES) == 0)
        else $error("card_address is not a multiple of the block size");

endmodule

bind audio_frame_top audio_frame_sva u_audio_frame_sva (
    .clock(clock),
    .reset(reset),
    .frame_ready(frame_ready),
    .frame_valid(frame_valid),
    .frame_sample(frame_sample),
    .card_address(card_address)
);

`default_nettype wire

// File: tb/audio_frame_tb.sv
`timescale 1ns/1ps
`default_nettype none

module audio_frame_tb;

    localparam int TICK_DIVIDER = 4;
    localparam int FRAME_LOG2   = 4;
    localparam int FRAME_LEN    = 2 ** FRAME_LOG2;
    localparam int HOP_LEN      = FRAME_LEN / 2;
    localparam int BLOCK_BYTES  = audio_frame_pkg::CARD_BLOCK_BYTES;
    localparam int NUM_FRAMES   = 150;
    // 1300 sample ticks, plus slack for card latency and the last frame
    localparam int WATCHDOG_CYCLES = 1300 * TICK_DIVIDER + 400;

    logic                           clock;
    logic                           reset;
    audio_frame_pkg::sample_byte_t  card_data;
    logic                           card_byte_strobe;
    logic                           frame_ready;
    logic                           card_read;
    audio_frame_pkg::card_address_t card_address;
    audio_frame_pkg::frame_sample_t frame_sample;
    logic                           frame_valid;
    logic                           frame_last;
    logic                           frame_done;
    logic                           frame_overrun;

    integer seed = 32'h8a323b0e;

    // every byte the card has sent, in order
    audio_frame_pkg::sample_byte_t card_bytes [$];

    int blocks_served  = 0;
    int frame_count    = 0;
    int sample_index   = 0;
    int sample_errors  = 0;
    int framing_errors = 0;
    int card_errors    = 0;
    int control_errors = 0;

    // position inside the current group of four ready cycles
    int ready_phase = 0;
    int stall_slot  = 0;

    logic                           done_expected = 1'b0;
    logic                           stalled       = 1'b0;
    audio_frame_pkg::frame_sample_t held_sample;

    tb_clock #(
        .HALF_PERIOD_NS(2),
        .RESET_CYCLES(2)
    ) u_tb_clock (
        .clock(clock),
        .reset(reset)
    );

    audio_frame_top #(
        .TICK_DIVIDER(TICK_DIVIDER),
        .FRAME_LOG2(FRAME_LOG2)
    ) dut (
        .clock(clock),
        .reset(reset),
        .card_data(card_data),
        .card_byte_strobe(card_byte_strobe),
        .frame_ready(frame_ready),
        .card_read(card_read),
        .card_address(card_address),
        .frame_sample(frame_sample),
        .frame_valid(frame_valid),
        .frame_last(frame_last),
        .frame_done(frame_done),
        .frame_overrun(frame_overrun)
    );

    // frame k starts one hop per frame into the byte stream, offset binary to signed
    function automatic audio_frame_pkg::frame_sample_t expected_sample(int frame, int index);
        int byte_value;
        byte_value = int'(card_bytes[frame * HOP_LEN + index]);
        return audio_frame_pkg::frame_sample_t'((byte_value - 128) * 256);
    endfunction

    initial
    begin
        card_data        = '0;
        card_byte_strobe = 1'b0;
        frame_ready      = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // card model
    //////////////////////////////////////////////////////////////////////

    // one block of random bytes, one strobe every two cycles
    task automatic send_block();
        int first;
        int n;
        first = card_bytes.size();
        repeat (BLOCK_BYTES) card_bytes.push_back(audio_frame_pkg::sample_byte_t'($random(seed)));
        for (n = 0; n < BLOCK_BYTES; n++)
        begin
            @(posedge clock);
            card_data        <= card_bytes[first + n];
            card_byte_strobe <= 1'b1;
            @(posedge clock);
            card_byte_strobe <= 1'b0;
        end
    endtask

    initial
    begin : card_model
        logic read_prev;
        read_prev = 1'b0;
        forever
        begin
            @(negedge clock);
            if (card_read === 1'b1 && read_prev !== 1'b1)
            begin
                assert (card_address === audio_frame_pkg::card_address_t'(BLOCK_BYTES * blocks_served))
                else
                begin
                    card_errors++;
                    $display("FAILED at %0t ns: request %0d reads address %0h, expected %0h",
                        $time, blocks_served, card_address, BLOCK_BYTES * blocks_served);
                end
                send_block();
                blocks_served++;
            end
            read_prev = card_read;
        end
    end

    // spectrum engine accepts 3 cycles in 4
    // the stall cycle within each group of four is drawn at random
    always @(posedge clock)
    begin
        if (ready_phase == 0)
        begin
            stall_slot = $random(seed) & 3;
        end
        frame_ready <= (ready_phase != stall_slot);
        ready_phase = (ready_phase + 1) % 4;
    end

    //////////////////////////////////////////////////////////////////////
    // output checks, sampled on the falling edge
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        @(negedge reset);
        @(negedge clock);
        assert (card_read === 1'b0 && frame_valid === 1'b0 && frame_last === 1'b0 &&
                frame_done === 1'b0 && frame_overrun === 1'b0 && card_address === '0)
        else
        begin
            control_errors++;
            $display("FAILED at %0t ns: control outputs are not in their reset state",
                $time);
        end
    end

    always @(negedge clock)
    begin : compare
        int                             byte_index;
        audio_frame_pkg::frame_sample_t expected;
        if (!reset)
        begin
            assert (frame_overrun === 1'b0)
            else
            begin
                control_errors++;
                $display("FAILED at %0t ns: frame_overrun set although every window fits",
                    $time);
            end
            assert (frame_done === done_expected)
            else
            begin
                framing_errors++;
                $display("FAILED at %0t ns: frame_done is %b, expected %b after frame %0d",
                    $time, frame_done, done_expected, frame_count);
            end
            done_expected = 1'b0;
            // a stalled sample must be the one offered now
            if (stalled)
            begin
                assert (frame_valid === 1'b1 && frame_sample === held_sample)
                else
                begin
                    framing_errors++;
                    $display("FAILED at %0t ns: sample dropped or changed during a stall",
                        $time);
                end
            end
            if (frame_valid === 1'b1 && frame_ready === 1'b1)
            begin
                byte_index = frame_count * HOP_LEN + sample_index;
                if (byte_index >= card_bytes.size())
                begin
                    sample_errors++;
                    $display("sample %0d of frame %0d arrived before its card byte",
                        sample_index, frame_count);
                end
                else
                begin
                    expected = expected_sample(frame_count, sample_index);
                    assert (frame_sample === expected)
                    else
                    begin
                        sample_errors++;
                        $display("FAILED at %0t ns: frame %0d sample %0d is %h, expected %h",
                            $time, frame_count, sample_index, frame_sample, expected);
                    end
                end
                assert (frame_last === (sample_index == FRAME_LEN - 1))
                else
                begin
                    framing_errors++;
                    $display("FAILED at %0t ns: frame_last is %b on sample %0d of frame %0d",
                        $time, frame_last, sample_index, frame_count);
                end
                // 16th transfer closes the frame
                if (sample_index == FRAME_LEN - 1)
                begin
                    done_expected = 1'b1;
                    sample_index  = 0;
                    frame_count++;
                end
                else
                begin
                    sample_index++;
                end
            end
            stalled     = (frame_valid === 1'b1 && frame_ready !== 1'b1);
            held_sample = frame_sample;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // end of run and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        while (frame_count < NUM_FRAMES) @(posedge clock);
        // let the last frame_done be checked
        repeat (2) @(posedge clock);
        $display("errors: %0d sample, %0d framing, %0d card, %0d control (%0d frames, %0d blocks)",
            sample_errors, framing_errors, card_errors, control_errors,
            frame_count, blocks_served);
        if (sample_errors + framing_errors + card_errors + control_errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles with %0d of %0d frames received",
            WATCHDOG_CYCLES, frame_count, NUM_FRAMES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// free-running clock and power-on reset for the testbench
module tb_clock #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES   = 2
) (
    output logic clock,
    output logic reset
);

    initial
    begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

    // reset held over the first rising edges, released on an edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire
